// ==== list.f ====
hci_pkg.sv
load_store_mixer.sv
load_source.sv
store_sink.sv
copy_ctrl.sv
hwpe_copy_top.sv
tb_mem_model.sv
tb_hwpe_copy_top.sv

// ==== Bender.yml ====
package:
  name: hwpe_copy

sources:
  - hci_pkg.sv
  - load_store_mixer.sv
  - load_source.sv
  - store_sink.sv
  - copy_ctrl.sv
  - hwpe_copy_top.sv
  - target: test
    files:
      - tb_mem_model.sv
      - tb_hwpe_copy_top.sv

// ==== tb_hwpe_copy_top.sv ====
//////////////////////////////
// copy accelerator testbench
// clock, reset, port monitor,
// directed tests, watchdog
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module tb_hwpe_copy_top;
  import hci_pkg::*;

  localparam int unsigned TOTAL_WORDS = 1 + 32 + 32 + 32 + 32 + 32;
  localparam int unsigned MAX_CYCLES  = 40 * TOTAL_WORDS + 200;

  logic        clk_i, rst_ni, clear_i, start, busy, done;
  addr_t       src_base, dst_base, cur_src, cur_dst;
  len_t        len, cur_len;
  core_req_t   mem_req, ld_req, st_req, ld_prev, st_prev;
  core_rsp_t   mem_rsp, ld_rsp, st_rsp;
  int unsigned stall_pct;
  int          errors, checks, rd_acc, wr_acc, rd_ret, ties, cycle_cnt;
  logic        ld_wait, st_wait, tie_seen, last_wen;
  string       cur_test;

  // channel side of the mixer
  assign ld_req = i_hwpe_copy_top.ld_req;
  assign st_req = i_hwpe_copy_top.st_req;
  assign ld_rsp = i_hwpe_copy_top.ld_rsp;
  assign st_rsp = i_hwpe_copy_top.st_rsp;

  hwpe_copy_top #(.FIFO_DEPTH(4)) i_hwpe_copy_top (
    .clk_i, .rst_ni, .clear_i, .start, .src_base, .dst_base, .len,
    .busy, .done, .mem_req, .mem_rsp
  );

  tb_mem_model i_tb_mem_model (.clk_i, .rst_ni, .stall_pct, .mem_req, .mem_rsp);

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  function automatic data_t src_word(input addr_t a);
    return {a ^ 16'h5a3c, ~a};
  endfunction

  function automatic data_t fill_word(input addr_t a);
    return {16'hdead, a}; // untouched destination
  endfunction

  task automatic expect_eq(input string what, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("Fail %s %s: expected %h, actual %h", cur_test, what, exp, act);
    end
  endtask

  task automatic report_error(input string msg);
    errors++;
    $display("%s: %s", cur_test, msg);
  endtask

  // watches the memory port and both mixer channels at every rising edge
  always @(posedge clk_i) begin : port_monitor
    logic acc;
    logic tie;
    acc = mem_req.req & mem_rsp.gnt;
    tie = ld_req.req & st_req.req;
    if (!rst_ni || clear_i) begin
      ld_wait  = 1'b0;
      st_wait  = 1'b0;
      tie_seen = 1'b0;
    end else begin
      if (ld_wait && ld_req.req && ld_req.add !== ld_prev.add)
        report_error("a read held without grant changed its address");
      if (st_wait && (!st_req.req || st_req.add !== st_prev.add || st_req.data !== st_prev.data))
        report_error("a write held without grant was dropped or changed");
      if (acc && mem_req.be !== '1)
        report_error("a request was accepted without full byte enables");
      if (acc && mem_req.wen) begin
        rd_acc++;
        if (addr_t'(mem_req.add - cur_src) >= cur_len) report_error("read outside the source");
      end
      if (acc && !mem_req.wen) begin
        if (wr_acc >= rd_ret) report_error("write accepted before its read returned");
        wr_acc++;
        if (addr_t'(mem_req.add - cur_dst) >= cur_len)
          report_error("write outside the destination");
      end
      if (acc && tie) begin
        ties++;
        if (tie_seen && mem_req.wen == last_wen) report_error("tied channels did not alternate");
      end
      if (acc) begin
        tie_seen = tie;
        last_wen = mem_req.wen;
      end
      if (mem_rsp.r_valid) rd_ret++;
      ld_wait = ld_req.req & ~ld_rsp.gnt;
      st_wait = st_req.req & ~st_rsp.gnt;
      ld_prev = ld_req;
      st_prev = st_req;
    end
  end

  task automatic start_copy(input addr_t src, input addr_t dst, input len_t n,
                            input int unsigned stall);
    for (int k = 0; k < n; k++)
      i_tb_mem_model.mem[src + addr_t'(k)] = src_word(src + addr_t'(k));
    for (int k = 0; k <= n; k++)
      i_tb_mem_model.mem[dst + addr_t'(k)] = fill_word(dst + addr_t'(k));
    cur_src   = src;
    cur_dst   = dst;
    cur_len   = n;
    rd_acc    = 0;
    wr_acc    = 0;
    rd_ret    = 0;
    ties      = 0;
    stall_pct = stall;
    src_base  = src;
    dst_base  = dst;
    len       = n;
    start     = 1'b1;
    @(negedge clk_i);
    start = 1'b0;
  endtask

  // destination word k must equal source word k
  task automatic finish_copy();
    while (!done) @(negedge clk_i);
    expect_eq("busy at done", 0, busy);
    for (int k = 0; k < cur_len; k++)
      expect_eq($sformatf("dst word %0d", k), src_word(cur_src + addr_t'(k)),
                i_tb_mem_model.mem[cur_dst + addr_t'(k)]);
    expect_eq("word past block", fill_word(cur_dst + cur_len),
              i_tb_mem_model.mem[cur_dst + cur_len]);
  endtask

  task automatic test_reset();
    cur_test = "test_reset";
    expect_eq("mem_req.req", 0, mem_req.req);
    expect_eq("busy", 0, busy);
    expect_eq("done", 0, done);
    start_copy(16'h0100, 16'h0200, 16'd0, 0);
    expect_eq("done after zero length", 1, done);
    repeat (4) @(negedge clk_i);
    expect_eq("done pulse", 0, done);
    expect_eq("accesses", 0, rd_acc + wr_acc);
  endtask

  task automatic test_single();
    cur_test = "test_single";
    start_copy(16'h0040, 16'h0080, 16'd1, 0);
    finish_copy();
    expect_eq("reads", 1, rd_acc);
    expect_eq("writes", 1, wr_acc);
  endtask

  task automatic test_block();
    cur_test = "test_block";
    start_copy(16'h1000, 16'h2000, 16'd32, 0);
    finish_copy();
    expect_eq("writes", 32, wr_acc);
  endtask

  task automatic test_backpressure();
    cur_test = "test_backpressure";
    start_copy(16'h1000, 16'h3000, 16'd32, 50);
    finish_copy();
  endtask

  task automatic test_fairness();
    cur_test = "test_fairness";
    start_copy(16'h1000, 16'h4000, 16'd32, 25);
    finish_copy();
    if (ties == 0) report_error("both channels never requested in the same cycle");
  endtask

  task automatic test_clear();
    cur_test = "test_clear";
    start_copy(16'h1000, 16'h5000, 16'd32, 50);
    while (wr_acc < 4) @(negedge clk_i);
    clear_i = 1'b1;
    @(negedge clk_i);
    clear_i = 1'b0;
    expect_eq("busy after clear", 0, busy);
    expect_eq("mem_req.req after clear", 0, mem_req.req);
    @(negedge clk_i);
    start_copy(16'h1000, 16'h6000, 16'd32, 50);
    finish_copy();
  endtask

  initial begin : watchdog
    cycle_cnt = 0;
    while (cycle_cnt < MAX_CYCLES) begin
      @(posedge clk_i);
      cycle_cnt++;
    end
    $display("timeout: tests did not finish within %0d cycles", MAX_CYCLES);
    $display("TB FAILED");
    $finish;
  end

  initial begin : main
    rst_ni    = 1'b0;
    clear_i   = 1'b0;
    start     = 1'b0;
    src_base  = '0;
    dst_base  = '0;
    len       = '0;
    stall_pct = 0;
    errors    = 0;
    checks    = 0;
    cur_len   = '0;
    cur_test  = "reset";
    repeat (16) @(negedge clk_i);
    rst_ni = 1'b1;
    @(negedge clk_i);
    test_reset();
    test_single();
    test_block();
    test_backpressure();
    test_fairness();
    test_clear();
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb_mem_model.sv ====
//////////////////////////////
// testbench memory, random
// grant and one-cycle reads
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module tb_mem_model (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  int unsigned        stall_pct,  // percent of cycles without grant
  input  hci_pkg::core_req_t mem_req,
  output hci_pkg::core_rsp_t mem_rsp
);
  import hci_pkg::*;

  data_t  mem [2**AW];
  integer seed = 32'h4c0f;
  logic   gnt_q;
  logic   rvalid_q;
  data_t  rdata_q;
  logic   acc;

  assign acc = mem_req.req & gnt_q;

  always_comb begin
    mem_rsp.gnt     = gnt_q;
    mem_rsp.r_valid = rvalid_q; // only after an accepted read
    mem_rsp.r_data  = rdata_q;
  end

  // grant is drawn every cycle, independent of the request
  always @(posedge clk_i or negedge rst_ni) begin : mem_port
    if (!rst_ni) begin
      gnt_q    <= 1'b1;
      rvalid_q <= 1'b0;
      rdata_q  <= '0;
    end else begin
      gnt_q    <= ($unsigned($random(seed)) % 100) >= stall_pct;
      rvalid_q <= acc & mem_req.wen;
      if (acc && mem_req.wen) begin
        rdata_q <= mem[mem_req.add];
      end
      if (acc && !mem_req.wen) begin
        for (int b = 0; b < DW/8; b++) begin
          if (mem_req.be[b]) mem[mem_req.add][8*b +: 8] = mem_req.data[8*b +: 8];
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== hwpe_copy_top.sv ====
//////////////////////////////
// memory copy accelerator top
// controller, load and store
// channels, load/store mixer
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module hwpe_copy_top #(
  parameter int unsigned FIFO_DEPTH = 4
) (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               clear_i,
  input  logic               start,
  input  hci_pkg::addr_t     src_base,
  input  hci_pkg::addr_t     dst_base,
  input  hci_pkg::len_t      len,
  output logic               busy,
  output logic               done,
  output hci_pkg::core_req_t mem_req,
  input  hci_pkg::core_rsp_t mem_rsp
);
  import hci_pkg::*;

  addr_t     src_q;
  addr_t     dst_q;
  len_t      len_q;
  logic      go;
  logic      ld_last;
  logic      st_last;
  logic      fifo_room;
  logic      word_valid;
  data_t     word_data;
  core_req_t ld_req;
  core_req_t st_req;
  core_rsp_t ld_rsp;
  core_rsp_t st_rsp;

  // job parameters, captured only when the controller accepts start
  always_ff @(posedge clk_i) begin
    if (start && !busy) begin
      src_q <= src_base;
      dst_q <= dst_base;
      len_q <= len;
    end
  end

  copy_ctrl i_copy_ctrl (
    .clk_i, .rst_ni, .clear_i, .start,
    .len     (len),     // raw input, zero length is decided at start
    .ld_last (ld_last),
    .st_last (st_last),
    .go      (go),
    .busy    (busy),
    .done    (done)
  );

  load_source i_load_source (
    .clk_i, .rst_ni, .clear_i, .go,
    .src_base   (src_q),
    .len        (len_q),
    .fifo_room  (fifo_room),
    .ld_req     (ld_req),
    .ld_rsp     (ld_rsp),
    .word_valid (word_valid),
    .word_data  (word_data),
    .last       (ld_last)
  );

  store_sink #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) i_store_sink (
    .clk_i, .rst_ni, .clear_i, .go,
    .dst_base   (dst_q),
    .len        (len_q),
    .word_valid (word_valid),
    .word_data  (word_data),
    .fifo_room  (fifo_room),
    .st_req     (st_req),
    .st_rsp     (st_rsp),
    .last       (st_last)
  );

  load_store_mixer i_load_store_mixer (
    .clk_i, .rst_ni, .clear_i,
    .ld_req  (ld_req),
    .st_req  (st_req),
    .ld_rsp  (ld_rsp),
    .st_rsp  (st_rsp),
    .mem_req (mem_req),
    .mem_rsp (mem_rsp)
  );

endmodule

`default_nettype wire

// ==== copy_ctrl.sv ====
//////////////////////////////
// copy controller FSM
// start, go, busy and done
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module copy_ctrl (
  input  logic          clk_i,
  input  logic          rst_ni,
  input  logic          clear_i,
  input  logic          start,
  input  hci_pkg::len_t len,
  input  logic          ld_last,
  input  logic          st_last,
  output logic          go,
  output logic          busy,
  output logic          done
);
  import hci_pkg::*;

  ctrl_state_e state_q;
  logic        go_q;
  logic        done_q;
  logic        ld_seen_q;  // load finished first

  assign go   = go_q;
  assign done = done_q;
  assign busy = (state_q != IDLE);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q   <= IDLE;
      go_q      <= 1'b0;
      done_q    <= 1'b0;
      ld_seen_q <= 1'b0;
    end else if (clear_i) begin
      state_q   <= IDLE;
      go_q      <= 1'b0;
      done_q    <= 1'b0;
      ld_seen_q <= 1'b0;
    end else begin
      go_q   <= 1'b0;
      done_q <= 1'b0;
      case (state_q)
        IDLE: begin
          if (start) begin
            if (len == '0) begin
              done_q <= 1'b1; // nothing to move
            end else begin
              state_q <= RUN;
              go_q    <= 1'b1;
            end
          end
        end
        RUN: begin
          if (ld_last && st_last) begin
            state_q <= IDLE;
            done_q  <= 1'b1;
          end else if (ld_last || st_last) begin
            state_q   <= DRAIN;
            ld_seen_q <= ld_last;
          end
        end
        DRAIN: begin
          // wait for the channel that has not finished yet
          if ((ld_seen_q && st_last) || (!ld_seen_q && ld_last)) begin
            state_q <= IDLE;
            done_q  <= 1'b1;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== store_sink.sv ====
//////////////////////////////
// store channel: word fifo and
// write address generator
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module store_sink #(
  parameter int unsigned FIFO_DEPTH = 4
) (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               clear_i,
  input  logic               go,
  input  hci_pkg::addr_t     dst_base,
  input  hci_pkg::len_t      len,
  input  logic               word_valid,
  input  hci_pkg::data_t     word_data,
  output logic               fifo_room,
  output hci_pkg::core_req_t st_req,
  input  hci_pkg::core_rsp_t st_rsp,
  output logic               last
);
  import hci_pkg::*;

  localparam int unsigned PW = $clog2(FIFO_DEPTH);
  localparam int unsigned CW = $clog2(FIFO_DEPTH + 1);

  data_t         fifo_mem [FIFO_DEPTH];
  logic [PW-1:0] rd_ptr_q;
  logic [PW-1:0] wr_ptr_q;
  logic [CW-1:0] fill_q;
  len_t          wr_cnt_q;   // words written so far
  logic          last_q;
  logic          push;
  logic          pop;

  // circular increment, depth need not be a power of two
  function automatic logic [PW-1:0] ptr_inc(input logic [PW-1:0] ptr);
    if (ptr == PW'(FIFO_DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign push = word_valid;
  assign pop  = st_req.req & st_rsp.gnt;

  // one slot for the read in flight, one for a read issued now
  assign fifo_room = (fill_q <= CW'(FIFO_DEPTH - 2));
  assign last      = last_q;

  always_comb begin : build_req
    st_req      = '0;
    st_req.req  = (fill_q != '0);
    st_req.add  = dst_base + addr_t'(wr_cnt_q);
    st_req.wen  = 1'b0;
    st_req.be   = '1;
    st_req.data = fifo_mem[rd_ptr_q]; // head word, held until granted
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      fifo_mem[wr_ptr_q] <= word_data;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      fill_q   <= '0;
      wr_cnt_q <= '0;
      last_q   <= 1'b0;
    end else if (clear_i) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      fill_q   <= '0;
      wr_cnt_q <= '0;
      last_q   <= 1'b0;
    end else begin
      if (push) wr_ptr_q <= ptr_inc(wr_ptr_q);
      if (pop)  rd_ptr_q <= ptr_inc(rd_ptr_q);
      case ({push, pop})
        2'b10:   fill_q <= fill_q + 1'b1;
        2'b01:   fill_q <= fill_q - 1'b1;
        default: fill_q <= fill_q;
      endcase
      last_q <= pop && (wr_cnt_q + len_t'(1) == len);
      if (go) begin
        wr_cnt_q <= '0;
      end else if (pop) begin
        wr_cnt_q <= wr_cnt_q + len_t'(1);
      end
    end
  end

endmodule

`default_nettype wire

// ==== load_source.sv ====
//////////////////////////////
// load channel: read address
// generator, forwards returned
// words to the store channel
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module load_source (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               clear_i,
  input  logic               go,
  input  hci_pkg::addr_t     src_base,
  input  hci_pkg::len_t      len,
  input  logic               fifo_room,
  output hci_pkg::core_req_t ld_req,
  input  hci_pkg::core_rsp_t ld_rsp,
  output logic               word_valid,
  output hci_pkg::data_t     word_data,
  output logic               last
);
  import hci_pkg::*;

  len_t iss_cnt_q;   // reads accepted so far
  len_t rx_cnt_q;    // words returned so far
  logic active_q;    // reads still to issue
  logic pend_q;      // read accepted last cycle, response due now
  logic last_q;
  logic rd_acc;

  always_comb begin : build_req
    ld_req      = '0;
    ld_req.req  = active_q & fifo_room; // stall while the store fifo is near full
    ld_req.add  = src_base + addr_t'(iss_cnt_q);
    ld_req.wen  = 1'b1;
    ld_req.be   = '1;
  end

  assign rd_acc = ld_req.req & ld_rsp.gnt;

  // drop a response whose read was issued before a clear
  assign word_valid = ld_rsp.r_valid & pend_q;
  assign word_data  = ld_rsp.r_data;
  assign last       = last_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      iss_cnt_q <= '0;
      rx_cnt_q  <= '0;
      active_q  <= 1'b0;
      pend_q    <= 1'b0;
      last_q    <= 1'b0;
    end else if (clear_i) begin
      iss_cnt_q <= '0;
      rx_cnt_q  <= '0;
      active_q  <= 1'b0;
      pend_q    <= 1'b0;
      last_q    <= 1'b0;
    end else begin
      pend_q <= rd_acc;
      last_q <= word_valid && (rx_cnt_q + len_t'(1) == len);
      if (go) begin
        iss_cnt_q <= '0;
        rx_cnt_q  <= '0;
        active_q  <= (len != '0);
      end else begin
        if (rd_acc) begin
          iss_cnt_q <= iss_cnt_q + len_t'(1);
          if (iss_cnt_q + len_t'(1) == len) begin
            active_q <= 1'b0; // final read is out
          end
        end
        if (word_valid) begin
          rx_cnt_q <= rx_cnt_q + len_t'(1);
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== load_store_mixer.sv ====
//////////////////////////////
// two-to-one load/store mixer
// round-robin grant on one port,
// responses routed by kind
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module load_store_mixer (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               clear_i,
  input  hci_pkg::core_req_t ld_req,
  input  hci_pkg::core_req_t st_req,
  output hci_pkg::core_rsp_t ld_rsp,
  output hci_pkg::core_rsp_t st_rsp,
  output hci_pkg::core_req_t mem_req,
  input  hci_pkg::core_rsp_t mem_rsp
);
  import hci_pkg::*;

  localparam logic LOAD  = 1'b0;
  localparam logic STORE = 1'b1;

  localparam core_rsp_t RSP_IDLE = '0;

  logic rr_q;      // channel favored on a tie, load after reset
  logic winner;
  logic accepted;

  // only a tie looks at the pointer
  always_comb begin : pick_winner
    if (ld_req.req && st_req.req) begin
      winner = rr_q;
    end else if (st_req.req) begin
      winner = STORE;
    end else begin
      winner = LOAD; // also the idle choice, ld_req.req is low then
    end
  end

  assign mem_req  = (winner == STORE) ? st_req : ld_req;
  assign accepted = mem_req.req & mem_rsp.gnt;

  // flips after every accepted request, so two busy channels alternate
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rr_q <= LOAD;
    end else if (clear_i) begin
      rr_q <= LOAD;
    end else if (accepted) begin
      rr_q <= ~rr_q;
    end
  end

  // grant goes to the winner only; responses follow their kind,
  // a read strobe belongs to load and everything else to store
  always_comb begin : route_rsp
    ld_rsp = RSP_IDLE;
    st_rsp = RSP_IDLE;

    ld_rsp.gnt = (winner == LOAD)  & ld_req.req & mem_rsp.gnt;
    st_rsp.gnt = (winner == STORE) & st_req.req & mem_rsp.gnt;

    if (mem_rsp.r_valid) begin
      ld_rsp.r_valid = 1'b1;
      ld_rsp.r_data  = mem_rsp.r_data;
    end else begin
      st_rsp.r_valid = mem_rsp.r_valid;
      st_rsp.r_data  = mem_rsp.r_data;
    end
  end

endmodule

`default_nettype wire

// ==== hci_pkg.sv ====
//////////////////////////////
// shared widths, memory port
// request/response structs and
// copy controller states
//////////////////////////////

`default_nettype none

package hci_pkg;

  // word-addressed memory geometry
  localparam int unsigned AW = 16;
  localparam int unsigned DW = 32;

  typedef logic [AW-1:0]   addr_t;  // word address
  typedef logic [DW-1:0]   data_t;
  typedef logic [DW/8-1:0] be_t;    // one enable per byte
  typedef logic [15:0]     len_t;   // transfer length in words

  // request side of the core memory port
  typedef struct packed {
    logic  req;
    addr_t add;
    logic  wen;   // 1 = read, 0 = write
    be_t   be;
    data_t data;
  } core_req_t;

  // response side, gnt in the request cycle and r_valid one cycle later
  typedef struct packed {
    logic  gnt;
    logic  r_valid;
    data_t r_data;
  } core_rsp_t;

  // copy controller
  typedef enum logic [1:0] {
    IDLE,
    RUN,   // both channels working
    DRAIN  // one last pulse seen, waiting for the other
  } ctrl_state_e;

endpackage

`default_nettype wire
